// ==== design/xc_geom_pkg.sv ====
// Correlator geometry: line count, lags, history depth and counter widths
// Vector types for the widths that carry a meaning

package xc_geom_pkg;

	// ################################################
	// Geometry
	// ################################################
	localparam int NUM_IN     = 4;                            // Pulse lines
	localparam int LAG_AUTO   = 2;                            // Auto lags per line
	localparam int LAG_CROSS  = 2;                            // Half width of the cross lag window
	localparam int CROSS_LAGS = 2 * LAG_CROSS - 1;            // Lags -1, 0 and +1
	localparam int NUM_PAIRS  = NUM_IN * (NUM_IN - 1) / 2;    // Line pairs
	localparam int HIST_DEPTH = 8;                            // Past samples kept per line

	// Pair order (0,1) (0,2) (0,3) (1,2) (1,3) (2,3)
	localparam int PAIR_A [NUM_PAIRS] = '{0, 0, 0, 1, 1, 2};
	localparam int PAIR_B [NUM_PAIRS] = '{1, 2, 3, 2, 3, 3};

	// ################################################
	// Counters and packet
	// ################################################
	localparam int COUNT_W    = 8;
	localparam int NUM_COUNTS = NUM_IN + NUM_IN * LAG_AUTO + NUM_PAIRS * CROSS_LAGS;
	localparam int AUTO_BASE  = NUM_IN;                       // First auto counter in packet order
	localparam int CROSS_BASE = NUM_IN + NUM_IN * LAG_AUTO;   // First cross counter in packet order
	localparam int PKT_WORDS  = NUM_COUNTS + 1;               // Header plus one word per counter

	localparam int WORD_W  = 16;
	localparam int SEQ_W   = 4;
	localparam int DELAY_W = 3;

	// Types
	typedef logic [NUM_IN-1:0]              sample_t;    // One bit per line
	typedef logic [$clog2(NUM_IN)-1:0]      line_idx_t;
	typedef logic [DELAY_W-1:0]             delay_t;
	typedef logic [COUNT_W-1:0]             count_t;
	typedef logic [WORD_W-1:0]              word_t;
	typedef logic [SEQ_W-1:0]               seq_t;
	typedef logic [$clog2(PKT_WORDS)-1:0]   word_idx_t;  // Position inside a packet

	localparam count_t COUNT_MAX = '1;                    // Saturation value

endpackage

// ==== design/xc_proto_pkg.sv ====
// Command opcodes and correlator configuration
// Counter snapshot, packer states and packet word

package xc_proto_pkg;

	import xc_geom_pkg::*;

	// ################################################
	// Command stream
	// ################################################
	// Opcode sits in bits 7:6 of a command byte
	typedef enum logic [1:0] {
		OP_SELECT    = 2'd0,  // Bits 1:0 pick the line later commands address
		OP_AUTO_DLY  = 2'd1,  // Bits 2:0 set the auto delay of the current line
		OP_CROSS_DLY = 2'd2,  // Bits 2:0 set the cross delay of the current line
		OP_CTRL      = 2'd3   // Bit 0 integrate, bit 1 invert of the current line
	} cmd_op_e;

	typedef struct packed {
		logic                   integrate;
		sample_t                invert;
		delay_t [NUM_IN-1:0]    auto_dly;
		delay_t [NUM_IN-1:0]    cross_dly;
	} xc_config_t;

	// ################################################
	// Results
	// ################################################
	typedef struct packed {
		count_t [NUM_IN-1:0]                      pulse;
		count_t [NUM_IN-1:0][LAG_AUTO-1:0]        auto_cnt;
		count_t [NUM_PAIRS-1:0][CROSS_LAGS-1:0]   cross_cnt;  // Lag index 0 is lag -1
		logic                                     ovf;        // Some counter hit full scale
	} xc_snapshot_t;

	typedef enum logic {
		PK_IDLE,
		PK_SEND
	} pkt_state_e;

	typedef struct packed {
		logic   valid;
		logic   last;   // Marks the final count word
		word_t  data;
	} xc_pkt_t;

	localparam logic [3:0] PKT_MAGIC = 4'hC;  // Header nibble that opens every packet

endpackage

// ==== design/xc_cmd_decoder.sv ====
// Command decoder for the correlator
// Keeps the addressed line and the per-line delay and invert registers

`timescale 1ns/1ps

module xc_cmd_decoder
	import xc_geom_pkg::*, xc_proto_pkg::*;
(
	input  logic        intclk,
	input  logic        rst_n,
	input  logic        cmd_valid,
	input  logic [7:0]  cmd_byte,
	output xc_config_t  cfg
);

	cmd_op_e   op;
	line_idx_t cur_line;  // Line addressed by the delay and invert commands

	assign op = cmd_op_e'(cmd_byte[7:6]);

	// ################################################
	// Configuration registers
	// ################################################
	// A command updates cfg at the edge it is accepted on
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			cur_line <= '0;
			cfg      <= '0;
		end else if (cmd_valid) begin
			unique case (op)
				OP_SELECT: begin
					cur_line <= line_idx_t'(cmd_byte[1:0]);
				end
				OP_AUTO_DLY: begin
					cfg.auto_dly[cur_line] <= delay_t'(cmd_byte[2:0]);
				end
				OP_CROSS_DLY: begin
					cfg.cross_dly[cur_line] <= delay_t'(cmd_byte[2:0]);
				end
				OP_CTRL: begin
					// Integrate is global, invert belongs to the current line
					cfg.integrate         <= cmd_byte[0];
					cfg.invert[cur_line]  <= cmd_byte[1];
				end
			endcase
		end
	end

	// ################################################
	// Checks
	// ################################################
	// A strobed byte must be fully driven or the opcode decode is meaningless
	assert property (@(posedge intclk) disable iff (!rst_n)
		cmd_valid |-> !$isunknown(cmd_byte))
		else $error("Command byte has unknown bits while cmd_valid is high");

endmodule

// ==== design/xc_lag_correlator.sv ====
// Lag correlator with per-line sample history
// Pulse, auto and cross lag products feeding saturating counters
// Snapshot and clear on an accepted frame

`timescale 1ns/1ps

module xc_lag_correlator
	import xc_geom_pkg::*, xc_proto_pkg::*;
(
	input  logic          intclk,
	input  logic          rst_n,
	input  sample_t       line_in,
	input  logic          sample_en,
	input  logic          frame,
	input  xc_config_t    cfg,
	input  logic          busy,
	output xc_snapshot_t  snap,
	output logic          snap_strobe
);

	sample_t       eff;                     // Sample after the invert bits
	sample_t       hist [HIST_DEPTH];       // hist[0] is one strobe old
	sample_t       taps [HIST_DEPTH+1];     // Tap 0 is the current sample
	logic [NUM_COUNTS-1:0] prod;            // One product per counter in packet order
	count_t        cnt      [NUM_COUNTS];
	count_t        cnt_next [NUM_COUNTS];
	logic          ovf;
	logic          ovf_next;
	logic          frame_take;
	logic          count_on;
	xc_snapshot_t  cur_snap;

	assign eff        = line_in ^ cfg.invert;
	assign frame_take = frame & ~busy;  // Frames during a packet are dropped
	assign count_on   = sample_en & cfg.integrate;

	// ################################################
	// History and lag products
	// ################################################
	always_comb begin
		taps[0] = eff;
		for (int d = 1; d <= HIST_DEPTH; d++)
			taps[d] = hist[d-1];
	end

	always_comb begin
		int a;
		int b;
		int lag;
		for (int l = 0; l < NUM_IN; l++)
			prod[l] = taps[0][l];
		for (int l = 0; l < NUM_IN; l++) begin
			for (int y = 0; y < LAG_AUTO; y++)
				prod[AUTO_BASE + l*LAG_AUTO + y] = taps[0][l] & taps[int'(cfg.auto_dly[l]) + y][l];
		end
		// A negative lag pushes line a further back, a positive one pushes line b
		for (int p = 0; p < NUM_PAIRS; p++) begin
			a = PAIR_A[p];
			b = PAIR_B[p];
			for (int k = 0; k < CROSS_LAGS; k++) begin
				lag = k - (LAG_CROSS - 1);
				prod[CROSS_BASE + p*CROSS_LAGS + k] =
					taps[int'(cfg.cross_dly[a]) + (lag < 0 ? -lag : 0)][a] &
					taps[int'(cfg.cross_dly[b]) + (lag > 0 ? lag : 0)][b];
			end
		end
	end

	// ################################################
	// Saturating counters
	// ################################################
	// A sample in the frame cycle lands in the fresh period
	always_comb begin
		count_t base;
		logic   hit;
		ovf_next = frame_take ? 1'b0 : ovf;
		for (int i = 0; i < NUM_COUNTS; i++) begin
			base = frame_take ? '0 : cnt[i];
			hit  = count_on & prod[i];
			if (hit && base != COUNT_MAX)
				cnt_next[i] = base + 1'b1;
			else
				cnt_next[i] = base;
			if (cnt_next[i] == COUNT_MAX)
				ovf_next = 1'b1;  // Sticky until the next accepted frame
		end
	end

	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			hist        <= '{default: '0};
			cnt         <= '{default: '0};
			ovf         <= 1'b0;
			snap_strobe <= 1'b0;
		end else begin
			if (sample_en) begin  // History shifts even with integrate off
				hist[0] <= eff;
				for (int d = 1; d < HIST_DEPTH; d++)
					hist[d] <= hist[d-1];
			end
			cnt         <= cnt_next;
			ovf         <= ovf_next;
			snap_strobe <= frame_take;
		end
	end

	// ################################################
	// Snapshot
	// ################################################
	always_comb begin
		for (int l = 0; l < NUM_IN; l++)
			cur_snap.pulse[l] = cnt[l];
		for (int l = 0; l < NUM_IN; l++)
			for (int y = 0; y < LAG_AUTO; y++)
				cur_snap.auto_cnt[l][y] = cnt[AUTO_BASE + l*LAG_AUTO + y];
		for (int p = 0; p < NUM_PAIRS; p++)
			for (int k = 0; k < CROSS_LAGS; k++)
				cur_snap.cross_cnt[p][k] = cnt[CROSS_BASE + p*CROSS_LAGS + k];
		cur_snap.ovf = ovf;
	end

	always_ff @(posedge intclk) begin
		if (frame_take)
			snap <= cur_snap;  // Values from before the clearing edge
	end

	// ################################################
	// Checks
	// ################################################
	assert property (@(posedge intclk) disable iff (!rst_n)
		snap_strobe |=> !snap_strobe)
		else $error("snap_strobe high on two cycles in a row");

	for (genvar g = 0; g < NUM_COUNTS; g++) begin : g_sat_chk
		assert property (@(posedge intclk) disable iff (!rst_n)
			(cnt[g] == COUNT_MAX && !frame_take) |=> cnt[g] != '0)
			else $error("Counter %0d wrapped from full scale", g);
	end

endmodule

// ==== design/xc_frame_packer.sv ====
// Frame packer: header word followed by the count words
// Owns the packet sequence number and the busy flag

`timescale 1ns/1ps

module xc_frame_packer
	import xc_geom_pkg::*, xc_proto_pkg::*;
(
	input  logic          intclk,
	input  logic          rst_n,
	input  xc_snapshot_t  snap,
	input  logic          snap_strobe,
	output logic          busy,
	output xc_pkt_t       pkt
);

	pkt_state_e state;
	word_idx_t  idx;            // Word being sent
	seq_t       seq;
	word_t      words [PKT_WORDS];
	logic       at_last;

	assign at_last = (idx == word_idx_t'(PKT_WORDS - 1));

	// ################################################
	// Packet order
	// ################################################
	always_comb begin
		words[0] = {PKT_MAGIC, seq, snap.ovf, 7'b0};
		for (int l = 0; l < NUM_IN; l++)
			words[1 + l] = word_t'(snap.pulse[l]);
		for (int l = 0; l < NUM_IN; l++)
			for (int y = 0; y < LAG_AUTO; y++)
				words[1 + AUTO_BASE + l*LAG_AUTO + y] = word_t'(snap.auto_cnt[l][y]);
		for (int p = 0; p < NUM_PAIRS; p++)
			for (int k = 0; k < CROSS_LAGS; k++)  // Lag -1, 0, +1
				words[1 + CROSS_BASE + p*CROSS_LAGS + k] = word_t'(snap.cross_cnt[p][k]);
	end

	// ################################################
	// Sender FSM
	// ################################################
	always_ff @(posedge intclk or negedge rst_n) begin
		if (!rst_n) begin
			state <= PK_IDLE;
			idx   <= '0;
			seq   <= '0;
		end else begin
			case (state)
				PK_IDLE: begin
					idx <= '0;
					if (snap_strobe)
						state <= PK_SEND;
				end
				PK_SEND: begin
					if (at_last) begin
						state <= PK_IDLE;
						seq   <= seq + 1'b1;  // Next packet gets the next number
					end else begin
						idx <= idx + 1'b1;
					end
				end
			endcase
		end
	end

	assign pkt.valid = (state == PK_SEND);
	assign pkt.last  = (state == PK_SEND) && at_last;
	assign pkt.data  = (state == PK_SEND) ? words[idx] : '0;

	// Covers the strobe cycle so a frame there cannot overwrite snap
	assign busy = snap_strobe | (state == PK_SEND);

	// ################################################
	// Checks
	// ################################################
	// The final word comes one packet length after the snapshot strobe
	assert property (@(posedge intclk) disable iff (!rst_n)
		pkt.last |-> pkt.valid && $past(snap_strobe, PKT_WORDS))
		else $error("pkt.last not on the final word after the snapshot strobe");

	assert property (@(posedge intclk) disable iff (!rst_n) snap_strobe |-> state != PK_SEND)
		else $error("Snapshot strobe arrived while a packet was streaming");

endmodule

// ==== design/xc_top.sv ====
// Correlator top level
// Command decoder, lag correlator and frame packer

`timescale 1ns/1ps

module xc_top
	import xc_geom_pkg::*, xc_proto_pkg::*;
(
	input  logic        intclk,
	input  logic        rst_n,
	input  sample_t     line_in,
	input  logic        sample_en,
	input  logic        cmd_valid,
	input  logic [7:0]  cmd_byte,
	input  logic        frame,
	output xc_pkt_t     pkt
);

	xc_config_t   cfg;
	xc_snapshot_t snap;
	logic         snap_strobe;
	logic         busy;         // Packer streaming, frames are ignored

	xc_cmd_decoder xc_cmd_decoder_inst (
		.intclk     (intclk),
		.rst_n      (rst_n),
		.cmd_valid  (cmd_valid),
		.cmd_byte   (cmd_byte),
		.cfg        (cfg)
	);

	xc_lag_correlator xc_lag_correlator_inst (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.line_in     (line_in),
		.sample_en   (sample_en),
		.frame       (frame),
		.cfg         (cfg),
		.busy        (busy),
		.snap        (snap),
		.snap_strobe (snap_strobe)
	);

	xc_frame_packer xc_frame_packer_inst (
		.intclk      (intclk),
		.rst_n       (rst_n),
		.snap        (snap),
		.snap_strobe (snap_strobe),
		.busy        (busy),
		.pkt         (pkt)
	);

endmodule

// ==== include/xc_tb_model.svh ====
// Reference model of the correlator for the testbench
// Command decode, sample history, lag products, saturation and packet order

`ifndef XC_TB_MODEL_SVH
`define XC_TB_MODEL_SVH

int      m_line;
logic    m_integrate;
sample_t m_invert;
int      m_auto  [NUM_IN];
int      m_cross [NUM_IN];
sample_t m_hist  [HIST_DEPTH];   // m_hist[0] is the previous strobe
count_t  m_cnt   [NUM_COUNTS];   // Kept in packet order
count_t  m_snap  [NUM_COUNTS];   // Counts captured by the last frame

task automatic clear_model();
	m_line      = 0;
	m_integrate = 1'b0;
	m_invert    = '0;
	for (int l = 0; l < NUM_IN; l++) begin
		m_auto[l]  = 0;
		m_cross[l] = 0;
	end
	for (int d = 0; d < HIST_DEPTH; d++)
		m_hist[d] = '0;
	for (int i = 0; i < NUM_COUNTS; i++) begin
		m_cnt[i]  = '0;
		m_snap[i] = '0;
	end
endtask

task automatic apply_command(input logic [7:0] b);
	case (b[7:6])
		2'd0: m_line = int'(b[1:0]);
		2'd1: m_auto[m_line] = int'(b[2:0]);
		2'd2: m_cross[m_line] = int'(b[2:0]);
		default: begin
			m_integrate      = b[0];
			m_invert[m_line] = b[1];
		end
	endcase
endtask

task automatic count_hit(input int i, input logic hit);
	if (hit && m_integrate) begin
		if (m_cnt[i] != 8'hFF)
			m_cnt[i] = m_cnt[i] + 8'd1;
	end
endtask

task automatic predict_sample(input sample_t s);
	sample_t tap [HIST_DEPTH+1];
	int      p;
	int      cb;
	tap[0] = s ^ m_invert;
	for (int d = 1; d <= HIST_DEPTH; d++)
		tap[d] = m_hist[d-1];
	for (int l = 0; l < NUM_IN; l++)
		count_hit(l, tap[0][l]);
	for (int l = 0; l < NUM_IN; l++)
		for (int y = 0; y < LAG_AUTO; y++)
			count_hit(NUM_IN + LAG_AUTO*l + y, tap[0][l] & tap[m_auto[l] + y][l]);
	p = 0;
	for (int a = 0; a < NUM_IN; a++) begin
		for (int b = a + 1; b < NUM_IN; b++) begin
			cb = NUM_IN + NUM_IN*LAG_AUTO + 3*p;
			count_hit(cb,     tap[m_cross[a] + 1][a] & tap[m_cross[b]][b]);
			count_hit(cb + 1, tap[m_cross[a]][a] & tap[m_cross[b]][b]);
			count_hit(cb + 2, tap[m_cross[a]][a] & tap[m_cross[b] + 1][b]);
			p++;
		end
	end
	for (int d = HIST_DEPTH - 1; d > 0; d--)
		m_hist[d] = m_hist[d-1];
	m_hist[0] = tap[0];
endtask

task automatic take_snapshot();
	for (int i = 0; i < NUM_COUNTS; i++) begin
		m_snap[i] = m_cnt[i];
		m_cnt[i]  = '0;
	end
endtask

`endif

// ==== verif/xc_tb.sv ====
// Testbench for the correlator top level
// Clock, reset, test table, per-test loop, packet checks and summary

`timescale 1ns/1ps

module xc_tb
	import xc_geom_pkg::*, xc_proto_pkg::*;
;

	logic       intclk;
	logic       rst_n;
	sample_t    line_in;
	logic       sample_en;
	logic       cmd_valid;
	logic [7:0] cmd_byte;
	logic       frame;
	xc_pkt_t    pkt;

	// One row per test with the first command in the top byte of cmds
	typedef struct {
		string       name;
		int          n_cmd;
		logic [31:0] cmds;
		int          n_samp;
		int          density;     // Percent chance that a line is high
		bit          busy_frame;  // Extra frame and samples while the packet streams
		seq_t        exp_seq;
		logic        exp_ovf;
	} test_row_t;

	test_row_t rows [$];
	int        err_count;
	int        pass_count;
	int        cycles;
	int        cycle_limit;

	`include "xc_tb_model.svh"

	xc_top xc_top_inst (
		.intclk    (intclk),
		.rst_n     (rst_n),
		.line_in   (line_in),
		.sample_en (sample_en),
		.cmd_valid (cmd_valid),
		.cmd_byte  (cmd_byte),
		.frame     (frame),
		.pkt       (pkt)
	);

	always #20 intclk = ~intclk;

	always @(posedge intclk) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("Timeout after %0d cycles, the test loop never finished", cycles);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	// ################################################
	// Helpers
	// ################################################
	task automatic add_row(input string name, input int n_cmd, input logic [31:0] cmds,
			input int n_samp, input int density, input bit busy_frame, input int exp_seq,
			input logic exp_ovf);
		test_row_t row;
		row.name       = name;
		row.n_cmd      = n_cmd;
		row.cmds       = cmds;
		row.n_samp     = n_samp;
		row.density    = density;
		row.busy_frame = busy_frame;
		row.exp_seq    = seq_t'(exp_seq);
		row.exp_ovf    = exp_ovf;
		rows.push_back(row);
	endtask

	task automatic idle_inputs();
		line_in   = '0;
		sample_en = 1'b0;
		cmd_valid = 1'b0;
		cmd_byte  = '0;
		frame     = 1'b0;
	endtask

	task automatic drive_sample(input int density);
		sample_t s;
		for (int l = 0; l < NUM_IN; l++)
			s[l] = (int'($urandom % 100) < density);
		line_in   = s;
		sample_en = 1'b1;
		predict_sample(s);
	endtask

	task automatic check_word(input int r, input int w);
		word_t exp_word;
		if (w == 0)
			exp_word = {PKT_MAGIC, rows[r].exp_seq, rows[r].exp_ovf, 7'b0};
		else
			exp_word = word_t'(m_snap[w-1]);
		if (!pkt.valid) begin
			$display("Test %s: valid dropped before word %0d", rows[r].name, w);
			err_count++;
		end
		if (w == PKT_WORDS - 1 && !pkt.last) begin
			$display("Test %s: last missing on the final word", rows[r].name);
			err_count++;
		end
		if (w != PKT_WORDS - 1 && pkt.last) begin
			$display("Test %s: last raised early on word %0d", rows[r].name, w);
			err_count++;
		end
		if (pkt.data !== exp_word) begin
			$display("Fail %s word %0d: pkt.data got %h expected %h",
				rows[r].name, w, pkt.data, exp_word);
			err_count++;
		end
	endtask

	// ################################################
	// Test loop
	// ################################################
	task automatic run_row(input int r);
		int errs_before;
		int wait_n;
		errs_before = err_count;
		for (int c = 0; c < rows[r].n_cmd; c++) begin
			@(negedge intclk);
			idle_inputs();
			cmd_valid = 1'b1;
			cmd_byte  = rows[r].cmds[31-8*c -: 8];
			apply_command(cmd_byte);
		end
		for (int i = 0; i < rows[r].n_samp; i++) begin
			@(negedge intclk);
			idle_inputs();
			drive_sample(rows[r].density);
		end
		@(negedge intclk);
		idle_inputs();
		frame = 1'b1;
		take_snapshot();
		wait_n = 0;
		do begin
			@(negedge intclk);
			idle_inputs();
			wait_n++;
		end while (!pkt.valid && wait_n < 40);
		if (!pkt.valid) begin
			$display("Test %s: no packet word arrived after the frame", rows[r].name);
			err_count++;
		end else begin
			if (wait_n != 2) begin
				$display("Fail %s: first pkt.valid latency got %h expected %h",
					rows[r].name, wait_n, 2);
				err_count++;
			end
			for (int w = 0; w < PKT_WORDS; w++) begin
				if (w > 0) begin
					@(negedge intclk);
					idle_inputs();
				end
				check_word(r, w);
				if (rows[r].busy_frame && w >= 3 && w <= 10) begin
					drive_sample(rows[r].density);
					frame = (w == 5);  // Ignored by the DUT while busy
				end
			end
		end
		if (err_count == errs_before)
			pass_count++;
		$display("Test %0d %-16s %s", r, rows[r].name,
			(err_count == errs_before) ? "passed" : "failed");
	endtask

	initial begin
		intclk      = 1'b0;
		rst_n       = 1'b0;
		err_count   = 0;
		pass_count  = 0;
		cycles      = 0;
		cycle_limit = 100;
		idle_inputs();
		void'($urandom(32'hd9a6));
		clear_model();
		add_row("reset_idle",     0, 32'h0000_0000,  20,  50, 0, 0, 1'b0);
		add_row("zero_delay",     1, 32'hC100_0000,  60,  50, 0, 1, 1'b0);
		add_row("delays",         4, 32'h0143_8502,  60,  40, 0, 2, 1'b0);  // Line 1 then line 2
		add_row("invert",         4, 32'h4681_00C3,  60,  50, 0, 3, 1'b0);
		add_row("integrate_off",  1, 32'hC200_0000,  40,  50, 0, 4, 1'b0);
		add_row("frame_busy",     1, 32'hC100_0000,  50,  50, 1, 5, 1'b0);
		add_row("after_busy",     0, 32'h0000_0000,  30,  50, 0, 6, 1'b0);
		add_row("saturate",       1, 32'hC100_0000, 300, 100, 0, 7, 1'b1);
		add_row("after_saturate", 0, 32'h0000_0000,   0,   0, 0, 8, 1'b0);
		foreach (rows[i])
			cycle_limit += rows[i].n_samp + 40;
		repeat (3) @(posedge intclk);
		@(negedge intclk);
		rst_n = 1'b1;
		foreach (rows[r])
			run_row(r);
		$display("Tests %0d, passed %0d, failed %0d, errors %0d",
			rows.size(), pass_count, rows.size() - pass_count, err_count);
		if (err_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+include
design/xc_geom_pkg.sv
design/xc_proto_pkg.sv
design/xc_cmd_decoder.sv
design/xc_lag_correlator.sv
design/xc_frame_packer.sv
design/xc_top.sv
verif/xc_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the correlator testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module xc_tb -o xc_sim \
	> build.log 2>&1 \
	&& ./obj_dir/xc_sim > sim.log 2>&1 \
	|| { echo "Build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "^NO ERRORS$" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
